/* design/busStageIf.sv */
// One bus cycle handed from a pipeline stage to the next; upstream binds source, downstream sink
`timescale 1ns/100ps
`default_nettype none

interface busStageIf;
    import z80BusPkg::*;

    logic                 valid;        // Stage holds a live cycle
    busFuncT              func;         // Cycle function
    tStateT               tState;       // T-state as seen by this stage
    logic [AddrWidth-1:0] addr;         // Cycle address
    logic [DataWidth-1:0] wdata;        // Byte to write

    // Upstream stage owns every field
    modport source (
        output valid,
        output func,
        output tState,
        output addr,
        output wdata
    );

    // No back-pressure, the next stage only listens
    modport sink (
        input valid,
        input func,
        input tState,
        input addr,
        input wdata
    );

endinterface

`default_nettype wire

/* design/cycleLauncher.sv */
// First bus stage: takes a request pulse, holds it for the sequencer and owns the BUSRQ grant
`timescale 1ns/100ps
`default_nettype none

module cycleLauncher (
    input  wire                             setM1,      // T-state clock
    input  wire                             arstN,
    input  wire                             req,        // One-clock request pulse
    input  wire z80BusPkg::busFuncT         func,
    input  wire [z80BusPkg::AddrWidth-1:0]  addr,
    input  wire [z80BusPkg::DataWidth-1:0]  wdata,
    input  wire                             busrq,      // External bus request
    input  wire                             seqBusy,    // Sequencer holds a cycle
    input  wire                             lastState,  // Sequencer in final T-state
    output logic                            ready,      // Request would be taken
    output logic                            busack,     // Bus granted away
    busStageIf.source                       launch
);
    import z80BusPkg::*;

    logic idle;             // Nothing in flight, bus still ours
    logic accept;           // Request taken this clock
    logic take;             // Sequencer loads the held cycle
    logic sampleEn;         // BUSRQ sampling point
    logic busrqLatch;       // BUSRQ as sampled

    assign idle     = ~launch.valid & ~seqBusy & ~busack;
    assign ready    = idle & ~busrqLatch;               // Pending grant blocks requests
    assign accept   = req & ready;
    assign take     = launch.valid & (~seqBusy | lastState);
    // A request on an idle clock wins over the grant
    assign sampleEn = lastState | (idle & ~accept);

    assign launch.tState = TIdle;                       // T-states start in the sequencer

    // --------------------
    // Request holding
    // --------------------
    always_ff @(posedge setM1 or negedge arstN) begin
        if (!arstN) begin
            launch.valid <= 1'b0;
        end else if (accept) begin
            launch.valid <= 1'b1;
        end else if (take) begin
            launch.valid <= 1'b0;                       // Handed to the sequencer
        end
    end

    always_ff @(posedge setM1) begin
        if (accept) begin
            launch.func  <= func;
            launch.addr  <= addr;
            launch.wdata <= wdata;
        end
    end

    // --------------------
    // Bus grant
    // --------------------
    // BUSACK trails the sampled BUSRQ by one clock so the pins are clear first
    always_ff @(posedge setM1 or negedge arstN) begin
        if (!arstN) begin
            busrqLatch <= 1'b0;
            busack     <= 1'b0;
        end else begin
            if (busack || sampleEn) begin
                busrqLatch <= busrq;                    // Tracked every clock while granted
            end
            busack <= busrqLatch;
        end
    end

endmodule

`default_nettype wire

/* design/padLatch.sv */
// Fourth bus stage: address and data pad latches, refresh counter, read data return and done
`timescale 1ns/100ps
`default_nettype none

module padLatch (
    input  wire                             setM1,
    input  wire                             arstN,
    busStageIf.sink                         pin,
    input  wire                             addrWe,
    input  wire                             refreshSel,
    input  wire                             dataOeRaw,
    input  wire                             dataCapture,
    input  wire                             cycleEnd,
    input  wire                             busack,
    input  wire [z80BusPkg::DataWidth-1:0]  dataIn,
    output logic [z80BusPkg::AddrWidth-1:0] addrOut,
    output logic                            addrOe,
    output logic [z80BusPkg::DataWidth-1:0] dataOut,
    output logic                            dataOe,
    output logic                            ctrlOe,
    output logic [z80BusPkg::DataWidth-1:0] rdata,      // Last read byte
    output logic                            done        // Cycle finished on the pins
);
    import z80BusPkg::*;

    logic [AddrWidth-1:0]    addrLatch;     // Address held past the cycle
    logic [RefreshWidth-1:0] refreshCnt;
    logic [DataWidth-1:0]    wdataLatch;
    logic [DataWidth-1:0]    capLatch;      // Byte sampled off the data pins
    logic                    addrLoad;
    logic                    isWrite;
    logic                    refreshEnd;    // Fetch or IntAck leaving T4

    assign addrLoad   = addrWe && pin.valid;
    assign isWrite    = (pin.func == FuncMemWrite) || (pin.func == FuncIoWrite);
    assign refreshEnd = cycleEnd && (pin.tState == T4);     // Only refresh cycles end in T4

    // --------------------
    // Pad drivers
    // --------------------
    // Latch is transparent in T1 so the address is out with the first strobe
    assign addrOut = refreshSel ? {{(AddrWidth-RefreshWidth){1'b0}}, refreshCnt}
                   : (addrLoad ? pin.addr : addrLatch);
    assign dataOut = (addrLoad && isWrite) ? pin.wdata : wdataLatch;

    // Granted bus means every driver released
    assign addrOe = ~busack;
    assign ctrlOe = ~busack;
    assign dataOe = dataOeRaw & ~busack;

    // --------------------
    // Latches
    // --------------------
    always_ff @(posedge setM1) begin
        if (addrLoad) begin
            addrLatch <= pin.addr;
        end
        if (addrLoad && isWrite) begin
            wdataLatch <= pin.wdata;
        end
        if (dataCapture) begin
            capLatch <= dataIn;         // Last clock of the capture state wins
        end
        // rdata moves only at cycle end, stable until the next done
        if (cycleEnd && !isWrite) begin
            rdata <= dataCapture ? dataIn : capLatch;
        end
    end

    always_ff @(posedge setM1 or negedge arstN) begin
        if (!arstN) begin
            refreshCnt <= '0;
            done       <= 1'b0;
        end else begin
            done <= cycleEnd;
            if (refreshEnd) begin
                refreshCnt <= refreshCnt + 1'b1;    // Wraps at 128
            end
        end
    end

endmodule

`default_nettype wire

/* design/pinControl.sv */
// Third bus stage: decodes function and T-state into registered strobes and pad-latch controls
`timescale 1ns/100ps
`default_nettype none

module pinControl (
    input  wire         setM1,
    input  wire         arstN,
    busStageIf.sink     seq,
    busStageIf.source   pin,            // Same cycle, aligned with the pins
    output logic        m1,
    output logic        mreq,
    output logic        iorq,
    output logic        rd,
    output logic        wr,
    output logic        rfsh,
    output logic        addrWe,         // Pins in T1, address pad load
    output logic        refreshSel,     // Address pads show refresh address
    output logic        dataOeRaw,      // Data pads driven, before grant gating
    output logic        dataCapture,    // Read data sampled at end of this clock
    output logic        cycleEnd        // Pins in the final T-state
);
    import z80BusPkg::*;

    logic inT1, inT2, inTwA, inTw1, inTw2, inT3, inT4;     // Decoded T-state
    logic m1Nx, mreqNx, iorqNx, rdNx, wrNx, rfshNx;        // Strobes for next clock
    logic dataOeNx, captureNx, endNx;

    assign inT1  = seq.valid && (seq.tState == T1);
    assign inT2  = seq.tState == T2;
    assign inTwA = seq.tState == TwA;
    assign inTw1 = seq.tState == Tw1;
    assign inTw2 = seq.tState == Tw2;
    assign inT3  = seq.tState == T3;
    assign inT4  = seq.tState == T4;

    // --------------------
    // Strobe table
    // --------------------
    always_comb begin
        m1Nx      = 1'b0;
        mreqNx    = 1'b0;
        iorqNx    = 1'b0;
        rdNx      = 1'b0;
        wrNx      = 1'b0;
        rfshNx    = 1'b0;
        dataOeNx  = 1'b0;
        captureNx = 1'b0;
        endNx     = 1'b0;
        case (seq.func)
            FuncFetch: begin
                m1Nx      = inT1 | inT2;
                mreqNx    = inT1 | inT2 | inT3 | inT4;   // Opcode then refresh
                rdNx      = inT1 | inT2;
                rfshNx    = inT3 | inT4;
                captureNx = inT2;                       // Opcode taken leaving T2
                endNx     = inT4;
            end
            FuncMemRead: begin
                mreqNx    = inT1 | inT2 | inT3;
                rdNx      = inT1 | inT2 | inT3;
                captureNx = inT3;
                endNx     = inT3;
            end
            FuncMemWrite: begin
                mreqNx    = inT1 | inT2 | inT3;
                wrNx      = inT2 | inT3;                // Data settles in T1 first
                dataOeNx  = inT1 | inT2 | inT3;
                endNx     = inT3;
            end
            FuncIoRead: begin
                iorqNx    = inT2 | inTwA | inT3;
                rdNx      = inT2 | inTwA | inT3;
                captureNx = inT3;
                endNx     = inT3;
            end
            FuncIoWrite: begin
                iorqNx    = inT2 | inTwA | inT3;
                wrNx      = inT2 | inTwA | inT3;
                dataOeNx  = inT1 | inT2 | inTwA | inT3;
                endNx     = inT3;
            end
            FuncIntAck: begin
                m1Nx      = inT1 | inT2 | inTw1 | inTw2;
                iorqNx    = inTw2;                      // Vector read window
                mreqNx    = inT3 | inT4;
                rfshNx    = inT3 | inT4;
                captureNx = inTw2;
                endNx     = inT4;
            end
            default: ;
        endcase
    end

    // --------------------
    // Pin registers
    // --------------------
    always_ff @(posedge setM1 or negedge arstN) begin
        if (!arstN) begin
            {m1, mreq, iorq, rd, wr, rfsh} <= '0;
            {addrWe, refreshSel, dataOeRaw, dataCapture, cycleEnd} <= '0;
            pin.valid  <= 1'b0;
            pin.tState <= TIdle;
        end else begin
            {m1, mreq, iorq, rd, wr, rfsh} <= {m1Nx, mreqNx, iorqNx, rdNx, wrNx, rfshNx};
            addrWe      <= inT1;
            refreshSel  <= rfshNx;                      // Refresh address under RFSH
            dataOeRaw   <= dataOeNx;
            dataCapture <= captureNx;
            cycleEnd    <= endNx;
            pin.valid   <= seq.valid;
            pin.tState  <= seq.tState;
        end
    end

    always_ff @(posedge setM1) begin
        pin.func  <= seq.func;
        pin.addr  <= seq.addr;
        pin.wdata <= seq.wdata;
    end

endmodule

`default_nettype wire

/* design/tStateSequencer.sv */
// Second bus stage: walks the T-states of each cycle function and stretches it on WAIT
`timescale 1ns/100ps
`default_nettype none

module tStateSequencer (
    input  wire         setM1,
    input  wire         arstN,
    input  wire         mwait,          // WAIT pin, high stretches the cycle
    busStageIf.sink     launch,
    busStageIf.source   seq,
    output logic        seqBusy,        // Any T-state but idle
    output logic        lastState       // Final T-state of the cycle
);
    import z80BusPkg::*;

    tStateT waitState;                  // Where WAIT is tested
    tStateT lastT;                      // Final state of this function
    tStateT nextState;
    logic   holdWait;                   // Repeat the current state
    logic   load;                       // Start the launched cycle in T1

    // --------------------
    // Per-function shape
    // --------------------
    always_comb begin
        case (seq.func)
            FuncIoRead,
            FuncIoWrite: waitState = TwA;
            FuncIntAck:  waitState = Tw2;
            default:     waitState = T2;        // Fetch and memory cycles
        endcase
    end

    // Fetch and IntAck carry the refresh half, so they end in T4
    assign lastT = (seq.func == FuncFetch || seq.func == FuncIntAck) ? T4 : T3;

    assign seq.valid = (seq.tState != TIdle);
    assign seqBusy   = seq.valid;
    assign lastState = seq.valid && (seq.tState == lastT);
    assign holdWait  = mwait && (seq.tState == waitState);
    assign load      = launch.valid && (!seq.valid || lastState);   // No idle clock between

    // --------------------
    // Next state
    // --------------------
    always_comb begin
        case (seq.tState)
            TIdle: nextState = TIdle;
            T1:    nextState = T2;
            T2: begin
                if (seq.func == FuncIoRead || seq.func == FuncIoWrite) begin
                    nextState = TwA;
                end else if (seq.func == FuncIntAck) begin
                    nextState = Tw1;
                end else begin
                    nextState = T3;
                end
            end
            TwA:   nextState = T3;
            Tw1:   nextState = Tw2;
            Tw2:   nextState = T3;
            T3:    nextState = (lastT == T3) ? TIdle : T4;
            T4:    nextState = TIdle;
            default: nextState = TIdle;
        endcase
        if (holdWait) begin
            nextState = seq.tState;             // Wait state, same T-state again
        end
        if (load) begin
            nextState = T1;
        end
    end

    always_ff @(posedge setM1 or negedge arstN) begin
        if (!arstN) begin
            seq.tState <= TIdle;
        end else begin
            seq.tState <= nextState;
        end
    end

    // Cycle payload follows the cycle into T1
    always_ff @(posedge setM1) begin
        if (load) begin
            seq.func  <= launch.func;
            seq.addr  <= launch.addr;
            seq.wdata <= launch.wdata;
        end
    end

endmodule

`default_nettype wire

/* design/z80BusPkg.sv */
// Bus function codes, T-state codes and pin widths shared by every stage of the bus unit
`default_nettype none

package z80BusPkg;

    // --------------------
    // Pin widths
    // --------------------
    localparam int AddrWidth    = 16;   // A15..A0
    localparam int DataWidth    = 8;    // D7..D0
    localparam int RefreshWidth = 7;    // Counting part of the refresh address

    // --------------------
    // Cycle functions
    // --------------------
    // One code per kind of machine cycle the core can ask for
    typedef enum logic [2:0] {
        FuncFetch    = 3'd0,            // Opcode fetch, M1 cycle with refresh
        FuncMemRead  = 3'd1,            // Memory read
        FuncMemWrite = 3'd2,            // Memory write
        FuncIoRead   = 3'd3,            // Port read, one automatic wait
        FuncIoWrite  = 3'd4,            // Port write, one automatic wait
        FuncIntAck   = 3'd5             // Interrupt acknowledge fetch
    } busFuncT;

    // --------------------
    // T-states
    // --------------------
    // TwA is the automatic I/O wait, Tw1/Tw2 the two IntAck waits
    typedef enum logic [2:0] {
        TIdle = 3'd0,                   // No cycle on the bus
        T1    = 3'd1,
        T2    = 3'd2,
        TwA   = 3'd3,
        Tw1   = 3'd4,
        Tw2   = 3'd5,
        T3    = 3'd6,
        T4    = 3'd7
    } tStateT;

endpackage

`default_nettype wire

/* design/z80BusUnit.sv */
// Top of the external bus unit: wires the launcher, sequencer, pin and pad stages to the pins
`timescale 1ns/100ps
`default_nettype none

module z80BusUnit (
    input  wire                             setM1,      // One clock per T-state
    input  wire                             arstN,
    // Core side
    input  wire                             req,
    input  wire z80BusPkg::busFuncT         func,
    input  wire [z80BusPkg::AddrWidth-1:0]  addr,
    input  wire [z80BusPkg::DataWidth-1:0]  wdata,
    output wire                             ready,
    output wire                             done,
    output wire [z80BusPkg::DataWidth-1:0]  rdata,
    // Pin side
    input  wire                             mwait,
    input  wire                             busrq,
    input  wire [z80BusPkg::DataWidth-1:0]  dataIn,
    output wire                             m1,
    output wire                             mreq,
    output wire                             iorq,
    output wire                             rd,
    output wire                             wr,
    output wire                             rfsh,
    output wire                             busack,
    output wire [z80BusPkg::AddrWidth-1:0]  addrOut,
    output wire                             addrOe,
    output wire [z80BusPkg::DataWidth-1:0]  dataOut,
    output wire                             dataOe,
    output wire                             ctrlOe
);

    // --------------------
    // Stage links
    // --------------------
    busStageIf launchToSeq ();          // Latched request
    busStageIf seqToPin ();             // Current T-state
    busStageIf pinToPad ();             // T-state one clock later

    logic seqBusy;
    logic lastState;
    logic addrWe;
    logic refreshSel;
    logic dataOeRaw;
    logic dataCapture;
    logic cycleEnd;

    cycleLauncher uLauncher (
        .setM1     (setM1),
        .arstN     (arstN),
        .req       (req),
        .func      (func),
        .addr      (addr),
        .wdata     (wdata),
        .busrq     (busrq),
        .seqBusy   (seqBusy),
        .lastState (lastState),
        .ready     (ready),
        .busack    (busack),
        .launch    (launchToSeq.source)
    );

    tStateSequencer uSequencer (
        .setM1     (setM1),
        .arstN     (arstN),
        .mwait     (mwait),
        .launch    (launchToSeq.sink),
        .seq       (seqToPin.source),
        .seqBusy   (seqBusy),
        .lastState (lastState)
    );

    pinControl uPinControl (
        .setM1       (setM1),
        .arstN       (arstN),
        .seq         (seqToPin.sink),
        .pin         (pinToPad.source),
        .m1          (m1),
        .mreq        (mreq),
        .iorq        (iorq),
        .rd          (rd),
        .wr          (wr),
        .rfsh        (rfsh),
        .addrWe      (addrWe),
        .refreshSel  (refreshSel),
        .dataOeRaw   (dataOeRaw),
        .dataCapture (dataCapture),
        .cycleEnd    (cycleEnd)
    );

    padLatch uPadLatch (
        .setM1       (setM1),
        .arstN       (arstN),
        .pin         (pinToPad.sink),
        .addrWe      (addrWe),
        .refreshSel  (refreshSel),
        .dataOeRaw   (dataOeRaw),
        .dataCapture (dataCapture),
        .cycleEnd    (cycleEnd),
        .busack      (busack),
        .dataIn      (dataIn),
        .addrOut     (addrOut),
        .addrOe      (addrOe),
        .dataOut     (dataOut),
        .dataOe      (dataOe),
        .ctrlOe      (ctrlOe),
        .rdata       (rdata),
        .done        (done)
    );

endmodule

`default_nettype wire

/* files.f */
design/z80BusPkg.sv
design/busStageIf.sv
design/cycleLauncher.sv
design/tStateSequencer.sv
design/pinControl.sv
design/padLatch.sv
design/z80BusUnit.sv
verification/z80BusUnitTb.sv

/* runSim.sh */
#!/bin/sh
# Build the bus unit testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing -sv -f files.f --top-module z80BusUnitTb -o z80BusUnitSim

# A $fatal in the testbench gives a failing exit status
./obj_dir/z80BusUnitSim

/* verification/z80BusUnitTb.sv */
// Random-stimulus testbench that runs each bus request against a device model and a cycle model
`timescale 1ns/100ps
`default_nettype none

module z80BusUnitTb;
    import z80BusPkg::*;

    localparam int NumRequests = 200;
    localparam int WaitLimit   = 100;       // Clocks any wait may take

    logic                 setM1 = 1'b0;
    logic                 arstN;
    logic                 req;
    busFuncT              func;
    logic [AddrWidth-1:0] addr;
    logic [DataWidth-1:0] wdata;
    logic                 mwait;
    logic                 busrq;
    logic [DataWidth-1:0] dataIn = '0;      // Driven by the device model
    wire                  ready;
    wire                  done;
    wire  [DataWidth-1:0] rdata;
    wire                  m1;
    wire                  mreq;
    wire                  iorq;
    wire                  rd;
    wire                  wr;
    wire                  rfsh;
    wire                  busack;
    wire  [AddrWidth-1:0] addrOut;
    wire                  addrOe;
    wire  [DataWidth-1:0] dataOut;
    wire                  dataOe;
    wire                  ctrlOe;

    logic [31:0]             rngState;
    logic [RefreshWidth-1:0] refreshModel;          // Expected refresh counter
    tStateT                  stateList[$];          // Pin T-states of the cycle in flight
    int                      writeCount = 0;        // WR pulses seen by the device
    logic [AddrWidth-1:0]    wrAddrSeen;
    logic [DataWidth-1:0]    wrDataSeen;
    logic                    wrPrev = 1'b0;

    z80BusUnit UUT (
        .setM1   (setM1),
        .arstN   (arstN),
        .req     (req),
        .func    (func),
        .addr    (addr),
        .wdata   (wdata),
        .ready   (ready),
        .done    (done),
        .rdata   (rdata),
        .mwait   (mwait),
        .busrq   (busrq),
        .dataIn  (dataIn),
        .m1      (m1),
        .mreq    (mreq),
        .iorq    (iorq),
        .rd      (rd),
        .wr      (wr),
        .rfsh    (rfsh),
        .busack  (busack),
        .addrOut (addrOut),
        .addrOe  (addrOe),
        .dataOut (dataOut),
        .dataOe  (dataOe),
        .ctrlOe  (ctrlOe)
    );

    always #2 setM1 = ~setM1;               // 4 ns T-state

    // --------------------
    // Device model
    // --------------------
    function automatic logic [DataWidth-1:0] deviceByte(input logic [AddrWidth-1:0] a);
        return a[7:0] ^ a[15:8] ^ 8'h5a;
    endfunction

    // Answers every read from the pins and logs each write at WR rise
    always @(posedge setM1) begin
        #1;
        dataIn = deviceByte(addrOut);
        if (wr && !wrPrev) begin
            writeCount = writeCount + 1;
            wrAddrSeen = addrOut;
            wrDataSeen = dataOut;
        end
        wrPrev = wr;
    end

    function automatic logic [31:0] nextRand();
        rngState = rngState * 32'd1664525 + 32'd1013904223;     // LCG step
        return rngState;
    endfunction

    // --------------------
    // Compare tasks
    // --------------------
    task automatic stopRun(input string what);
        $display("%s", what);
        $display("Simulation failed");
        $fatal(1, "Run stopped at first error");
    endtask

    task automatic checkBit(input string name, input logic got, input logic exp);
        if (got !== exp) stopRun($sformatf("FAIL %s: got %h, expected %h", name, got, exp));
    endtask

    task automatic checkData(input string name, input logic [DataWidth-1:0] got,
                             input logic [DataWidth-1:0] exp);
        if (got !== exp) stopRun($sformatf("FAIL %s: got %h, expected %h", name, got, exp));
    endtask

    task automatic checkAddr(input string name, input logic [AddrWidth-1:0] got,
                             input logic [AddrWidth-1:0] exp);
        if (got !== exp) stopRun($sformatf("FAIL %s: got %h, expected %h", name, got, exp));
    endtask

    task automatic checkFunc(input string name, input busFuncT got, input busFuncT exp);
        if (got !== exp) stopRun($sformatf("FAIL %s: got %h, expected %h", name, got, exp));
    endtask

    task automatic checkCount(input string name, input int got, input int exp);
        if (got != exp) stopRun($sformatf("FAIL %s: got %h, expected %h", name, got, exp));
    endtask

    // --------------------
    // Cycle model
    // --------------------
    // Pin T-states of one cycle with the tested state repeated on WAIT
    task automatic buildStates(input busFuncT f, input int waits, output int waitIdx);
        stateList.delete();
        stateList.push_back(T1);
        stateList.push_back(T2);
        if (f == FuncIoRead || f == FuncIoWrite) stateList.push_back(TwA);
        if (f == FuncIntAck) begin
            stateList.push_back(Tw1);
            stateList.push_back(Tw2);
        end
        waitIdx = stateList.size() - 1;                         // Tested state is the last one so far
        repeat (waits) stateList.push_back(stateList[waitIdx]);
        stateList.push_back(T3);
        if (f == FuncFetch || f == FuncIntAck) stateList.push_back(T4);
    endtask

    function automatic logic isRefresh(input busFuncT f, input tStateT s);
        return (f == FuncFetch || f == FuncIntAck) && (s inside {T3, T4});
    endfunction

    // {m1, mreq, iorq, rd, wr, rfsh, dataOe} expected in one pin T-state
    function automatic logic [6:0] expectedPins(input busFuncT f, input tStateT s);
        logic m;
        logic mr;
        logic io;
        logic r;
        logic w;
        logic rf;
        logic oe;
        m  = 1'b0;
        mr = 1'b0;
        io = 1'b0;
        r  = 1'b0;
        w  = 1'b0;
        rf = 1'b0;
        oe = 1'b0;
        case (f)
            FuncFetch: begin
                m  = s inside {T1, T2};
                mr = 1'b1;                                      // Opcode read then refresh
                r  = s inside {T1, T2};
                rf = s inside {T3, T4};
            end
            FuncMemRead: begin
                mr = 1'b1;
                r  = 1'b1;
            end
            FuncMemWrite: begin
                mr = 1'b1;
                w  = s inside {T2, T3};
                oe = 1'b1;
            end
            FuncIoRead: begin
                io = (s != T1);                                 // Waits included
                r  = (s != T1);
            end
            FuncIoWrite: begin
                io = (s != T1);
                w  = (s != T1);
                oe = 1'b1;
            end
            FuncIntAck: begin
                m  = s inside {T1, T2, Tw1, Tw2};
                io = (s == Tw2);
                mr = s inside {T3, T4};
                rf = s inside {T3, T4};
            end
            default: ;
        endcase
        return {m, mr, io, r, w, rf, oe};
    endfunction

    // Cycle kind as a device would read it from the first strobe
    function automatic busFuncT decodeFunc(input logic pm1, input logic pmreq, input logic prd);
        if (pm1) return pmreq ? FuncFetch : FuncIntAck;
        if (pmreq) return prd ? FuncMemRead : FuncMemWrite;
        return prd ? FuncIoRead : FuncIoWrite;
    endfunction

    // --------------------
    // Stimulus tasks
    // --------------------
    task automatic checkPins(input busFuncT f, input logic [AddrWidth-1:0] a,
                             input logic [DataWidth-1:0] d, input int idx);
        logic [6:0]           exp;
        logic [AddrWidth-1:0] expAddr;
        exp = '0;                                               // Idle pins outside the cycle
        if (idx >= 0 && idx < stateList.size()) begin
            exp = expectedPins(f, stateList[idx]);
            expAddr = isRefresh(f, stateList[idx]) ?
                      {{(AddrWidth-RefreshWidth){1'b0}}, refreshModel} : a;
            checkAddr("addrOut", addrOut, expAddr);
            checkBit("addrOe", addrOe, 1'b1);
            checkBit("ctrlOe", ctrlOe, 1'b1);
            if (exp[2]) checkData("dataOut", dataOut, d);    // Data valid under WR
        end
        checkBit("m1", m1, exp[6]);
        checkBit("mreq", mreq, exp[5]);
        checkBit("iorq", iorq, exp[4]);
        checkBit("rd", rd, exp[3]);
        checkBit("wr", wr, exp[2]);
        checkBit("rfsh", rfsh, exp[1]);
        checkBit("dataOe", dataOe, exp[0]);
    endtask

    task automatic waitReady();
        int n;
        n = 0;
        while (!ready) begin
            @(posedge setM1);
            #1;
            n = n + 1;
            if (n >= WaitLimit) stopRun("Timeout: ready never came back");
        end
    endtask

    // Holds the grant with BUSRQ already high and makes sure the bus stays released
    task automatic holdGrant(input int holdClocks);
        int n;
        n = 0;
        while (!busack) begin
            @(posedge setM1);
            #1;
            n = n + 1;
            if (n >= WaitLimit) stopRun("Timeout: busack never rose");
        end
        for (n = 0; n < holdClocks; n++) begin
            checkBit("ready", ready, 1'b0);
            checkBit("addrOe", addrOe, 1'b0);
            checkBit("ctrlOe", ctrlOe, 1'b0);
            checkBit("dataOe", dataOe, 1'b0);
            checkBit("strobes", m1 | mreq | iorq | rd | wr | rfsh, 1'b0);
            if (n > 0) checkBit("done", done, 1'b0);            // First clock still shows the last done
            req = (n == 0);                                     // Must be ignored
            @(posedge setM1);
            #1;
        end
        req   = 1'b0;
        busrq = 1'b0;
        n = 0;
        while (busack) begin
            @(posedge setM1);
            #1;
            n = n + 1;
            if (n >= WaitLimit) stopRun("Timeout: busack never fell");
        end
    endtask

    task automatic runCycle(input busFuncT f, input logic [AddrWidth-1:0] a,
                            input logic [DataWidth-1:0] d, input int waits, input int grabClocks);
        int t;
        int waitIdx;
        int waitFrom;
        int len;
        int writesBefore;
        bit seenStrobe;
        buildStates(f, waits, waitIdx);
        len          = stateList.size();
        waitFrom     = waitIdx + 1;                             // Sequencer clock of the tested state
        writesBefore = writeCount;
        seenStrobe   = 1'b0;
        waitReady();
        req   = 1'b1;
        func  = f;
        addr  = a;
        wdata = d;
        @(posedge setM1);                                       // Acceptance edge
        #1;
        req = 1'b0;
        t   = 0;
        do begin
            @(posedge setM1);
            #1;
            t = t + 1;
            mwait = (t >= waitFrom) && (t < waitFrom + waits);
            if (grabClocks > 0 && t == 1) busrq = 1'b1;
            if (!seenStrobe && (m1 || mreq || iorq)) begin
                seenStrobe = 1'b1;
                checkFunc("cycle kind", decodeFunc(m1, mreq, rd), f);
            end
            checkPins(f, a, d, t - 2);                          // Pins trail acceptance by two
            checkBit("done", done, t == len + 2);
            if (t >= WaitLimit) stopRun("Timeout: done never pulsed");
        end while (!done);
        mwait = 1'b0;
        if (f inside {FuncFetch, FuncMemRead, FuncIoRead, FuncIntAck}) begin
            checkData("rdata", rdata, deviceByte(a));
        end
        if (f == FuncMemWrite || f == FuncIoWrite) begin
            checkCount("write strobes", writeCount, writesBefore + 1);
            checkAddr("write address", wrAddrSeen, a);
            checkData("write data", wrDataSeen, d);
        end else begin
            checkCount("write strobes", writeCount, writesBefore);
        end
        if (f == FuncFetch || f == FuncIntAck) refreshModel = refreshModel + 1'b1;    // Mod 128
        if (grabClocks > 0) holdGrant(grabClocks);
    endtask

    // --------------------
    // Main sequence
    // --------------------
    initial begin
        logic [31:0]          r;
        logic [AddrWidth-1:0] a;
        logic [DataWidth-1:0] d;
        int                   sel;
        int                   waits;
        int                   grabClocks;
        arstN = 1'b0;
        req   = 1'b0;
        func  = FuncFetch;
        addr  = '0;
        wdata = '0;
        mwait = 1'b0;
        busrq = 1'b0;
        rngState     = 32'ha7fc_ac07;
        refreshModel = '0;
        repeat (10) @(posedge setM1);
        #1;
        arstN = 1'b1;
        checkBit("ready", ready, 1'b1);                         // Reset state of the unit
        checkBit("busack", busack, 1'b0);
        checkBit("done", done, 1'b0);
        checkBit("addrOe", addrOe, 1'b1);
        checkBit("ctrlOe", ctrlOe, 1'b1);
        checkBit("dataOe", dataOe, 1'b0);
        checkBit("strobes", m1 | mreq | iorq | rd | wr | rfsh, 1'b0);
        for (int i = 0; i < NumRequests; i++) begin
            r = nextRand();
            a = r[31:16];
            r = nextRand();
            d          = r[31:24];
            waits      = int'(r[23:22]);
            grabClocks = (r[21:19] == 3'd0) ? 2 + int'(r[18:16]) : 0;   // Roughly one in eight
            r = nextRand();
            sel = int'(r[31:16]) % 6;
            runCycle(busFuncT'(sel[2:0]), a, d, waits, grabClocks);
        end
        $display("Simulation passed");
        $finish;
    end

endmodule

`default_nettype wire
